// ==== Makefile ====
# Verilator build and run for the asymmetric two-port RAM
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= asym_ram_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TEST PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only when the pass message shows up on a line of its own
run: build
	@out="$$($(SIM_BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
+incdir+include
logic/asym_ram_pkg.sv
logic/bank_if.sv
logic/write_splitter.sv
logic/ram_bank.sv
logic/read_gather.sv
logic/asym_ram_2p.sv
verification/asym_ram_assert.sv
verification/asym_ram_tb.sv

// ==== include/asym_ram_macros.svh ====
`ifndef ASYM_RAM_MACROS_SVH
`define ASYM_RAM_MACROS_SVH

// port data widths
`define ASYM_W_DATA_W 32
`define ASYM_R_DATA_W 8

// address width of the narrower port, in narrow words
`define ASYM_ADDR_W 10

// larger and smaller of the two data widths
`define ASYM_MAX_W ((`ASYM_W_DATA_W > `ASYM_R_DATA_W) ? `ASYM_W_DATA_W : `ASYM_R_DATA_W)
`define ASYM_MIN_W ((`ASYM_W_DATA_W < `ASYM_R_DATA_W) ? `ASYM_W_DATA_W : `ASYM_R_DATA_W)

// bank count is the width ratio
`define ASYM_NBANK (`ASYM_MAX_W / `ASYM_MIN_W)

// address of one bank, narrow address minus the lane select bits
`define ASYM_BANK_ADDR_W (`ASYM_ADDR_W - $clog2(`ASYM_NBANK))

// wide port sees bank addresses, narrow port the full narrow address
`define ASYM_W_ADDR_W ((`ASYM_W_DATA_W == `ASYM_MAX_W) ? `ASYM_BANK_ADDR_W : `ASYM_ADDR_W)
`define ASYM_R_ADDR_W ((`ASYM_R_DATA_W == `ASYM_MAX_W) ? `ASYM_BANK_ADDR_W : `ASYM_ADDR_W)

`endif

// ==== logic/asym_ram_2p.sv ====
`timescale 1ns/1ps
`include "asym_ram_macros.svh"

module asym_ram_2p (
   input  logic                      clk_i,
   input  logic                      rst_i,

   // write port
   input  logic                      w_en_i,
   input  logic [`ASYM_W_ADDR_W-1:0] w_addr_i,
   input  logic [`ASYM_W_DATA_W-1:0] w_data_i,

   // read port, one cycle latency
   input  logic                      r_en_i,
   input  logic [`ASYM_R_ADDR_W-1:0] r_addr_i,
   output logic [`ASYM_R_DATA_W-1:0] r_data_o
);

   // one interface per bank
   bank_if u_bank_if [`ASYM_NBANK] ();

   // write side fan out
   write_splitter u_write_splitter (
      .w_en_i   (w_en_i),
      .w_addr_i (w_addr_i),
      .w_data_i (w_data_i),
      .banks    (u_bank_if)
   );

   // symmetric banks, one narrow lane each
   for (genvar g = 0; g < `ASYM_NBANK; g++) begin : g_bank
      ram_bank u_bank (
         .clk_i (clk_i),
         .rst_i (rst_i),
         .port  (u_bank_if[g])
      );
   end

   // read side address fan out and data select
   read_gather u_read_gather (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .r_en_i   (r_en_i),
      .r_addr_i (r_addr_i),
      .banks    (u_bank_if),
      .r_data_o (r_data_o)
   );

endmodule

// ==== logic/asym_ram_pkg.sv ====
`include "asym_ram_macros.svh"

package asym_ram_pkg;

   // lane select needs at least one bit, even with a single bank
   localparam int unsigned LANE_SEL_W = (`ASYM_NBANK > 1) ? $clog2(`ASYM_NBANK) : 1;

   // one bank data word, narrow width
   typedef logic [`ASYM_MIN_W-1:0] lane_t;

   // address inside one bank
   typedef logic [`ASYM_BANK_ADDR_W-1:0] bank_addr_t;

   // picks one bank out of the set
   // taken from the low bits of a narrow address
   typedef logic [LANE_SEL_W-1:0] lane_sel_t;

endpackage

// ==== logic/bank_if.sv ====
`timescale 1ns/1ps

// one bank worth of write and read port signals
interface bank_if
   import asym_ram_pkg::*;
   ();

   // write side
   logic       w_en;
   bank_addr_t w_addr;
   lane_t      w_data;

   // read side, data comes back one cycle after r_en
   logic       r_en;
   bank_addr_t r_addr;
   lane_t      r_data;

   // write splitter end
   modport wr (
      output w_en,
      output w_addr,
      output w_data
   );

   // read gather end
   modport rd (
      output r_en,
      output r_addr,
      input  r_data
   );

   // memory bank end
   modport mem (
      input  w_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface

// ==== logic/ram_bank.sv ====
`timescale 1ns/1ps

module ram_bank
   import asym_ram_pkg::*;
   (
   input  logic clk_i,
   input  logic rst_i,
   bank_if.mem  port
   );

   localparam int unsigned DEPTH = 1 << $bits(bank_addr_t);

   // storage, one narrow lane per entry
   lane_t mem [DEPTH];

   // write port
   always_ff @(posedge clk_i) begin
      if (port.w_en) begin
         mem[port.w_addr] <= port.w_data;
      end
   end

   // registered read
   // sampled before the write above lands, so a collision returns old data
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         port.r_data <= '0;
      end else if (port.r_en) begin
         port.r_data <= mem[port.r_addr];
      end
   end

endmodule

// ==== logic/read_gather.sv ====
`timescale 1ns/1ps
`include "asym_ram_macros.svh"

module read_gather
   import asym_ram_pkg::*;
   (
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  logic                      r_en_i,
   input  logic [`ASYM_R_ADDR_W-1:0] r_addr_i,
   bank_if.rd                        banks [`ASYM_NBANK],
   output logic [`ASYM_R_DATA_W-1:0] r_data_o
   );

   // read data from each bank, already registered inside the bank
   lane_t      lane_rdata [`ASYM_NBANK];
   bank_addr_t r_bank_addr;

   // every bank gets the same address and strobe
   for (genvar g = 0; g < `ASYM_NBANK; g++) begin : g_bank
      assign banks[g].r_en   = r_en_i;
      assign banks[g].r_addr = r_bank_addr;
      assign lane_rdata[g]   = banks[g].r_data;
   end

   if (`ASYM_W_DATA_W > `ASYM_R_DATA_W) begin : g_narrow_rd
      lane_sel_t r_sel_q;

      assign r_bank_addr = r_addr_i[`ASYM_R_ADDR_W-1 -: `ASYM_BANK_ADDR_W];

      // lane select follows the bank read register by one cycle
      // so the mux lines up with the data it picks
      always_ff @(posedge clk_i) begin
         if (rst_i) begin
            r_sel_q <= '0;
         end else if (r_en_i) begin
            r_sel_q <= lane_sel_t'(r_addr_i);
         end
      end

      // held select keeps the output stable between reads
      assign r_data_o = lane_rdata[r_sel_q];
   end else if (`ASYM_W_DATA_W < `ASYM_R_DATA_W) begin : g_wide_rd
      assign r_bank_addr = r_addr_i;

      // lane k of the wide word comes from bank k
      for (genvar g = 0; g < `ASYM_NBANK; g++) begin : g_lane
         assign r_data_o[g*`ASYM_MIN_W +: `ASYM_MIN_W] = lane_rdata[g];
      end
   end else begin : g_equal_rd
      assign r_bank_addr = r_addr_i;
      assign r_data_o    = lane_rdata[0];
   end

endmodule

// ==== logic/write_splitter.sv ====
`timescale 1ns/1ps
`include "asym_ram_macros.svh"

module write_splitter
   import asym_ram_pkg::*;
   (
   input  logic                      w_en_i,
   input  logic [`ASYM_W_ADDR_W-1:0] w_addr_i,
   input  logic [`ASYM_W_DATA_W-1:0] w_data_i,
   bank_if.wr                        banks [`ASYM_NBANK]
   );

   // per bank write controls before they go out on the interfaces
   logic [`ASYM_NBANK-1:0] lane_en;
   lane_t                  lane_wdata [`ASYM_NBANK];
   bank_addr_t             w_bank_addr;

   if (`ASYM_W_DATA_W > `ASYM_R_DATA_W) begin : g_wide_wr
      // whole wide word lands at one bank address, one lane per bank
      assign w_bank_addr = w_addr_i;

      for (genvar g = 0; g < `ASYM_NBANK; g++) begin : g_lane
         assign lane_en[g]    = w_en_i;
         assign lane_wdata[g] = w_data_i[g*`ASYM_MIN_W +: `ASYM_MIN_W];
      end
   end else if (`ASYM_W_DATA_W < `ASYM_R_DATA_W) begin : g_narrow_wr
      lane_sel_t w_sel;

      // upper bits address the bank, low bits pick which bank
      assign w_bank_addr = w_addr_i[`ASYM_W_ADDR_W-1 -: `ASYM_BANK_ADDR_W];
      assign w_sel       = lane_sel_t'(w_addr_i);

      for (genvar g = 0; g < `ASYM_NBANK; g++) begin : g_lane
         assign lane_en[g]    = w_en_i & (w_sel == lane_sel_t'(g));
         // all banks see the same data, only one is enabled
         assign lane_wdata[g] = w_data_i;
      end
   end else begin : g_equal_wr
      // single bank, straight through
      assign w_bank_addr   = w_addr_i;
      assign lane_en[0]    = w_en_i;
      assign lane_wdata[0] = w_data_i;
   end

   // drive the bank interfaces
   for (genvar g = 0; g < `ASYM_NBANK; g++) begin : g_drive
      assign banks[g].w_en   = lane_en[g];
      assign banks[g].w_addr = w_bank_addr;
      assign banks[g].w_data = lane_wdata[g];
   end

endmodule

// ==== verification/asym_ram_assert.sv ====
`timescale 1ns/1ps
`include "asym_ram_macros.svh"

module asym_ram_assert
   import asym_ram_pkg::*;
   (
   input logic                      clk_i,
   input logic                      rst_i,
   input logic                      w_en_i,
   input logic [`ASYM_W_ADDR_W-1:0] w_addr_i,
   input logic [`ASYM_W_DATA_W-1:0] w_data_i,
   input logic                      r_en_i,
   input logic [`ASYM_R_ADDR_W-1:0] r_addr_i,
   input logic [`ASYM_R_DATA_W-1:0] r_data_o
   );

   localparam int unsigned DEPTH = 1 << `ASYM_ADDR_W;

   typedef logic [`ASYM_ADDR_W-1:0] byte_addr_t;

   // byte level copy of the memory, plus which bytes hold known data
   lane_t            shadow [DEPTH];
   logic [DEPTH-1:0] written;

   // read issued at the last rising edge
   logic       ren_q;
   logic       chk_q;
   logic       coll_q;
   logic       rd_done_q;
   byte_addr_t raddr_q;
   lane_t      exp_q;

   // output value seen at the previous falling edge
   logic [`ASYM_R_DATA_W-1:0] rdata_prev;

   // one sticky flag per check
   logic fail_zero = 1'b0;
   logic fail_data = 1'b0;
   logic fail_coll = 1'b0;
   logic fail_hold = 1'b0;
   logic any_fail;

   assign any_fail = fail_zero | fail_data | fail_coll | fail_hold;

   // wide word a fills bytes 4a to 4a+3, lane k at byte 4a+k
   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         for (int k = 0; k < `ASYM_NBANK; k++) begin
            shadow[{w_addr_i, lane_sel_t'(k)}] <= w_data_i[k*`ASYM_MIN_W +: `ASYM_MIN_W];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         written <= '0;
      end else if (w_en_i) begin
         for (int k = 0; k < `ASYM_NBANK; k++) begin
            written[{w_addr_i, lane_sel_t'(k)}] <= 1'b1;
         end
      end
   end

   // read hits the word written at the same edge
   logic r_coll;

   assign r_coll = w_en_i & (w_addr_i == r_addr_i[`ASYM_ADDR_W-1 -: `ASYM_BANK_ADDR_W]);

   // expected value taken from the shadow before this edge's write lands
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ren_q     <= 1'b0;
         chk_q     <= 1'b0;
         coll_q    <= 1'b0;
         rd_done_q <= 1'b0;
         raddr_q   <= '0;
         exp_q     <= '0;
      end else begin
         ren_q  <= r_en_i;
         chk_q  <= r_en_i & written[r_addr_i] & ~r_coll;
         coll_q <= r_en_i & written[r_addr_i] & r_coll;
         if (r_en_i) begin
            raddr_q   <= r_addr_i;
            exp_q     <= shadow[r_addr_i];
            rd_done_q <= 1'b1;
         end
      end
   end

   always_ff @(negedge clk_i) begin
      rdata_prev <= r_data_o;
   end

   // checks sample on the falling edge, half a cycle after the DUT registers update

   a_zero_after_reset: assert property (@(negedge clk_i) disable iff (rst_i)
      !rd_done_q |-> (r_data_o == '0))
   else begin
      fail_zero = 1'b1;
      $error("[ERROR] %0t read data 0x%h before the first read, expected 0x00",
             $time, r_data_o);
   end

   // reads with no write to the same word at that edge
   a_read_data: assert property (@(negedge clk_i) disable iff (rst_i)
      chk_q |-> (r_data_o == exp_q))
   else begin
      fail_data = 1'b1;
      $error("[ERROR] %0t read addr 0x%h expected 0x%h got 0x%h",
             $time, raddr_q, exp_q, r_data_o);
   end

   // same byte written and read at one edge gives the old byte
   a_collision_old: assert property (@(negedge clk_i) disable iff (rst_i)
      coll_q |-> (r_data_o == exp_q))
   else begin
      fail_coll = 1'b1;
      $error("[ERROR] %0t collision at addr 0x%h expected old 0x%h got 0x%h",
             $time, raddr_q, exp_q, r_data_o);
   end

   a_hold_idle: assert property (@(negedge clk_i) disable iff (rst_i)
      !ren_q |-> (r_data_o == rdata_prev))
   else begin
      fail_hold = 1'b1;
      $error("[ERROR] %0t read data changed with no read, expected 0x%h got 0x%h",
             $time, rdata_prev, r_data_o);
   end

endmodule

// ==== verification/asym_ram_tb.sv ====
`timescale 1ns/1ps
`include "asym_ram_macros.svh"

module asym_ram_tb
   import asym_ram_pkg::*;
   ();

   localparam int W_AW = `ASYM_W_ADDR_W;
   localparam int W_DW = `ASYM_W_DATA_W;
   localparam int R_AW = `ASYM_R_ADDR_W;
   localparam int R_DW = `ASYM_R_DATA_W;

   localparam int          CLK_HALF        = 4;
   localparam int          WATCHDOG_CYCLES = 20000;
   localparam int          DRAIN_LIMIT     = 16;
   localparam int          N_WIDE          = 1 << W_AW;
   localparam int          N_READS         = 300;
   localparam int          N_MIXED         = 200;
   localparam int          N_COLL          = 40;
   localparam logic [31:0] SEED            = 32'ha00c_c19d;

   typedef logic [W_AW-1:0] w_addr_t;
   typedef logic [W_DW-1:0] w_data_t;
   typedef logic [R_AW-1:0] r_addr_t;

   logic            clk_i;
   logic            rst_i;
   logic            w_en_i;
   w_addr_t         w_addr_i;
   w_data_t         w_data_i;
   logic            r_en_i;
   r_addr_t         r_addr_i;
   logic [R_DW-1:0] r_data_o;

   asym_ram_2p u_asym_ram_2p (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .w_en_i   (w_en_i),
      .w_addr_i (w_addr_i),
      .w_data_i (w_data_i),
      .r_en_i   (r_en_i),
      .r_addr_i (r_addr_i),
      .r_data_o (r_data_o)
   );

   // checker sits inside the DUT and watches its ports
   bind asym_ram_2p asym_ram_assert u_asym_ram_assert (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .w_en_i   (w_en_i),
      .w_addr_i (w_addr_i),
      .w_data_i (w_data_i),
      .r_en_i   (r_en_i),
      .r_addr_i (r_addr_i),
      .r_data_o (r_data_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #CLK_HALF clk_i = ~clk_i;
   end

   task automatic idle(input int cycles);
      repeat (cycles) @(posedge clk_i);
   endtask

   task automatic write_word(input w_addr_t addr, input w_data_t data);
      w_en_i   <= 1'b1;
      w_addr_i <= addr;
      w_data_i <= data;
      @(posedge clk_i);
      w_en_i   <= 1'b0;
   endtask

   // back to back calls keep r_en_i high across the edges
   task automatic read_byte(input r_addr_t addr);
      r_en_i   <= 1'b1;
      r_addr_i <= addr;
      @(posedge clk_i);
      r_en_i   <= 1'b0;
   endtask

   // write a wide word and read one of its bytes at the same edge
   task automatic collide(input w_addr_t addr, input lane_sel_t lane, input w_data_t data);
      w_en_i   <= 1'b1;
      w_addr_i <= addr;
      w_data_i <= data;
      r_en_i   <= 1'b1;
      r_addr_i <= r_addr_t'({addr, lane});
      @(posedge clk_i);
      w_en_i   <= 1'b0;
      r_en_i   <= 1'b0;
   endtask

   task automatic fill_memory();
      for (int a = 0; a < N_WIDE; a++) begin
         write_word(w_addr_t'(a), w_data_t'($urandom));
      end
   endtask

   task automatic random_reads();
      for (int i = 0; i < N_READS; i++) begin
         read_byte(r_addr_t'($urandom));
         // mostly bursts, now and then a short gap
         if ($urandom_range(3, 0) == 0) begin
            idle(int'($urandom_range(3, 1)));
         end
      end
   endtask

   // rewrite the word just read while the read port idles
   task automatic mixed_traffic();
      r_addr_t addr;
      for (int i = 0; i < N_MIXED; i++) begin
         addr = r_addr_t'($urandom);
         read_byte(addr);
         case ($urandom_range(2, 0))
            0: write_word(w_addr_t'(addr >> LANE_SEL_W), w_data_t'($urandom));
            1: idle(1);
            default: write_word(w_addr_t'($urandom), w_data_t'($urandom));
         endcase
      end
   endtask

   task automatic collisions();
      w_addr_t   addr;
      lane_sel_t lane;
      for (int i = 0; i < N_COLL; i++) begin
         addr = w_addr_t'($urandom);
         lane = lane_sel_t'($urandom);
         collide(addr, lane, w_data_t'($urandom));
         // read back the new byte straight away or after a pause
         if ($urandom_range(1, 0) == 0) begin
            idle(1);
         end
         read_byte(r_addr_t'({addr, lane}));
      end
   endtask

   // let the last read retire before the run ends
   task automatic drain_reads();
      int waited;
      waited = 0;
      @(negedge clk_i);
      while (u_asym_ram_2p.u_asym_ram_assert.ren_q && waited < DRAIN_LIMIT) begin
         waited++;
         @(negedge clk_i);
      end
      if (u_asym_ram_2p.u_asym_ram_assert.ren_q) begin
         $display("TEST FAIL");
         $fatal(1, "timed out waiting for the last read to complete");
      end else begin
         @(posedge clk_i);
      end
   endtask

   // stop at the first failed check
   always @(posedge clk_i) begin
      if (u_asym_ram_2p.u_asym_ram_assert.any_fail) begin
         $display("TEST FAIL");
         $fatal(1, "an assertion in the read checker failed");
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("TEST FAIL");
      $fatal(1, "simulation ran past %0d cycles without finishing", WATCHDOG_CYCLES);
   end

   initial begin
      rst_i    = 1'b1;
      w_en_i   = 1'b0;
      w_addr_i = '0;
      w_data_i = '0;
      r_en_i   = 1'b0;
      r_addr_i = '0;
      void'($urandom(SEED));

      idle(2);
      rst_i <= 1'b0;

      // output must stay zero through the fill, no read yet
      idle(3);
      fill_memory();
      random_reads();
      drain_reads();
      mixed_traffic();
      collisions();
      drain_reads();

      if (u_asym_ram_2p.u_asym_ram_assert.any_fail) begin
         $display("TEST FAIL");
         $fatal(1, "an assertion in the read checker failed");
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule
